// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - design/rv_core_pkg.sv
  - design/rv_decode_if.sv
  - design/rv_alu.sv
  - design/rv_decoder.sv
  - design/rv_regfile.sv
  - design/rv_store_align.sv
  - design/rv_control.sv
  - design/rv_core.sv
  - target: test
    files:
      - tb/rv_bus_checker.sv
      - tb/rv_core_properties.sv
      - tb/rv_core_tb.sv

// ==== design/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu
    import rv_core_pkg::*;
    (
    input alu_op_t op,
    input word_t lhs,
    input word_t rhs,
    output word_t res
);

    always_comb begin
        res = '0;
        case (op)
            alu_add: res = lhs + rhs;
            alu_sub: res = lhs - rhs;
            alu_sll: res = lhs << rhs[4:0];
            alu_xor: res = lhs ^ rhs;
            alu_srl: res = lhs >> rhs[4:0];
            alu_sra: res = $signed(lhs) >>> rhs[4:0];
            alu_or: res = lhs | rhs;
            alu_and: res = lhs & rhs;
            // compares return 0 or 1
            alu_slt: res[0] = $signed(lhs) < $signed(rhs);
            alu_sltu: res[0] = lhs < rhs;
            alu_eq: res[0] = lhs == rhs;
            alu_ne: res[0] = lhs != rhs;
            alu_ge: res[0] = $signed(lhs) >= $signed(rhs);
            alu_geu: res[0] = lhs >= rhs;
            default: res = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_control
    import rv_core_pkg::*;
    #(
    parameter word_t reset_pc = 32'h1000_0000
) (
    input wire clk,
    input wire reset_n,
    input wire ready,
    input word_t read_data,
    input wire read_data_valid,
    output word_t addr,
    output word_t write_data,
    output byte_en_t byte_enable,
    output logic write_req,
    output logic read_req,
    output word_t instruction,
    output word_t pc,
    rv_decode_if.control dec,
    output logic reg_wr_en,
    output word_t reg_wr_data
);

    ctrl_state_t state, state_next;
    word_t pc_next, addr_next, write_data_next, instruction_next;
    byte_en_t byte_enable_next;
    logic write_req_next, read_req_next;
    counter_t cycle, instret, instret_next;
    alu_op_t alu_op, alu_op_next;
    word_t alu_lhs, alu_lhs_next, alu_rhs, alu_rhs_next, alu_res;
    word_t store_word, align_data, link, pc_target, wb_data;
    byte_en_t align_en;
    logic split, writes_rd, csr_bad, wb_fail;

    rv_alu i_alu (.op(alu_op), .lhs(alu_lhs), .rhs(alu_rhs), .res(alu_res));

    rv_store_align i_store_align (
        .width(dec.funct3), .offset(alu_res[1:0]), .data(dec.rs2_value),
        .second_beat(state == st_store_second),
        .wdata(align_data), .byte_en(align_en), .split(split)
    );

    assign store_word = {alu_res[31:2], 2'b00};
    assign link = pc + 32'd4;

    // register data and next pc for the retiring instruction
    always_comb begin
        pc_target = link;
        wb_data = alu_res;
        writes_rd = 1'b0;
        csr_bad = 1'b0;
        case (dec.opcode)
            opc_lui, opc_auipc, opc_op_imm, opc_op: writes_rd = 1'b1;
            opc_jal, opc_jalr: begin
                writes_rd = 1'b1;
                wb_data = link;
                pc_target = (dec.opcode == opc_jal) ? alu_res : {alu_res[31:1], 1'b0};
            end
            opc_branch: if (alu_res[0]) pc_target = pc + dec.branch_offset;
            opc_system: begin
                // funct3 000 is ecall/ebreak, retired as a no-op
                if (dec.funct3 != 3'b000) begin
                    writes_rd = 1'b1;
                    case (dec.csr)
                        csr_cycle: wb_data = cycle[31:0];
                        csr_instret: wb_data = instret[31:0];
                        csr_cycleh: wb_data = cycle[63:32];
                        csr_instreth: wb_data = instret[63:32];
                        default: csr_bad = 1'b1;
                    endcase
                end
            end
            default: ;
        endcase
    end

    assign wb_fail = csr_bad || pc_target[1:0] != 2'b00;
    assign reg_wr_en = state == st_writeback && ready && writes_rd && !wb_fail;
    assign reg_wr_data = wb_data;

    always_comb begin
        state_next = state;
        pc_next = pc;
        addr_next = addr;
        write_data_next = write_data;
        byte_enable_next = byte_enable;
        write_req_next = write_req;
        read_req_next = read_req;
        instret_next = instret;
        instruction_next = instruction;
        alu_op_next = alu_op;
        alu_lhs_next = alu_lhs;
        alu_rhs_next = alu_rhs;
        case (state)
            st_fetch_setup: begin
                addr_next = pc;
                byte_enable_next = 4'hf;
                read_req_next = 1'b1;
                state_next = st_fetch;
            end
            st_fetch: begin
                if (ready) read_req_next = 1'b0;
                if (read_data_valid) begin
                    instruction_next = read_data;
                    read_req_next = 1'b0;
                    state_next = st_decode;
                end
            end
            st_decode: begin
                alu_op_next = dec.alu_op;
                alu_lhs_next = dec.lhs;
                alu_rhs_next = dec.rhs;
                if (dec.illegal) state_next = st_error;
                else if (dec.opcode == opc_store) state_next = st_store_first;
                else state_next = st_writeback;
            end
            st_store_first: begin
                addr_next = store_word;
                write_data_next = align_data;
                byte_enable_next = align_en;
                write_req_next = 1'b1;
                state_next = split ? st_store_second : st_writeback;
            end
            st_store_second: begin
                // wait for the first beat to be taken
                if (ready) begin
                    addr_next = store_word + 32'd4;
                    write_data_next = align_data;
                    byte_enable_next = align_en;
                    state_next = st_writeback;
                end
            end
            st_writeback: begin
                if (ready) begin
                    write_req_next = 1'b0;
                    if (wb_fail) begin
                        state_next = st_error;
                    end else begin
                        pc_next = pc_target;
                        addr_next = pc_target;
                        byte_enable_next = 4'hf;
                        read_req_next = 1'b1;
                        instret_next = instret + 64'd1;
                        state_next = st_fetch;
                    end
                end
            end
            st_error: ;
            default: state_next = st_error;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_fetch_setup;
            pc <= reset_pc;
            addr <= '0;
            byte_enable <= '0;
            write_req <= 1'b0;
            read_req <= 1'b0;
            cycle <= '0;
            instret <= '0;
        end else begin
            state <= state_next;
            pc <= pc_next;
            addr <= addr_next;
            byte_enable <= byte_enable_next;
            write_req <= write_req_next;
            read_req <= read_req_next;
            cycle <= cycle + 64'd1;
            instret <= instret_next;
        end
    end

    always_ff @(posedge clk) begin
        instruction <= instruction_next;
        write_data <= write_data_next;
        alu_op <= alu_op_next;
        alu_lhs <= alu_lhs_next;
        alu_rhs <= alu_rhs_next;
    end

endmodule

`default_nettype wire

// ==== design/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core
    import rv_core_pkg::*;
    #(
    parameter word_t reset_pc = 32'h1000_0000
) (
    input wire reset_n,
    input wire clk,
    input wire ready,
    output word_t addr,
    output word_t write_data,
    output byte_en_t byte_enable,
    output logic write_req,
    output logic read_req,
    input word_t read_data,
    input wire read_data_valid
);

    word_t instruction, pc;
    reg_idx_t rs1, rs2;
    word_t rs1_value, rs2_value;
    logic reg_wr_en;
    word_t reg_wr_data;

    rv_decode_if dec_if ();

    rv_control #(.reset_pc(reset_pc)) i_control (
        .clk(clk), .reset_n(reset_n),
        .ready(ready), .read_data(read_data), .read_data_valid(read_data_valid),
        .addr(addr), .write_data(write_data), .byte_enable(byte_enable),
        .write_req(write_req), .read_req(read_req),
        .instruction(instruction), .pc(pc), .dec(dec_if.control),
        .reg_wr_en(reg_wr_en), .reg_wr_data(reg_wr_data)
    );

    rv_decoder i_decoder (
        .instruction(instruction), .pc(pc),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .rs1(rs1), .rs2(rs2), .dec(dec_if.decoder)
    );

    // write index straight from the decoded rd
    rv_regfile i_regfile (
        .clk(clk), .reset_n(reset_n),
        .rs1(rs1), .rs2(rs2), .rs1_value(rs1_value), .rs2_value(rs2_value),
        .wr_en(reg_wr_en), .wr_idx(dec_if.rd), .wr_data(reg_wr_data)
    );

endmodule

`default_nettype wire

// ==== design/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] byte_en_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] counter_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl,
        alu_sra, alu_or, alu_and, alu_eq, alu_ne, alu_ge, alu_geu
    } alu_op_t;

    typedef enum logic [2:0] {
        st_fetch_setup,
        st_fetch,
        st_decode,
        st_store_first,
        st_store_second,
        st_writeback,
        st_error
    } ctrl_state_t;

    // major opcodes
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_misc_mem = 7'b0001111;
    localparam logic [6:0] opc_system = 7'b1110011;

    // store widths in funct3
    localparam logic [2:0] width_byte = 3'b000;
    localparam logic [2:0] width_half = 3'b001;
    localparam logic [2:0] width_word = 3'b010;

    localparam csr_addr_t csr_cycle = 12'hc00;
    localparam csr_addr_t csr_instret = 12'hc02;
    localparam csr_addr_t csr_cycleh = 12'hc80;
    localparam csr_addr_t csr_instreth = 12'hc82;

endpackage

`default_nettype wire

// ==== design/rv_decode_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface rv_decode_if
    import rv_core_pkg::*;
    ();

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t rd;
    word_t rs2_value;
    word_t branch_offset;
    csr_addr_t csr;
    alu_op_t alu_op;
    word_t lhs;
    word_t rhs;
    logic illegal;

    modport decoder (
        output opcode, funct3, rd, rs2_value, branch_offset, csr, alu_op, lhs, rhs, illegal
    );

    modport control (
        input opcode, funct3, rs2_value, branch_offset, csr, alu_op, lhs, rhs, illegal
    );

endinterface

`default_nettype wire

// ==== design/rv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decoder
    import rv_core_pkg::*;
    (
    input word_t instruction,
    input word_t pc,
    input word_t rs1_value,
    input word_t rs2_value,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    rv_decode_if.decoder dec
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t store_imm;
    word_t jump_imm;
    word_t branch_imm;
    word_t i_imm;
    word_t u_imm;
    alu_op_t arith_op;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];

    assign store_imm = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign jump_imm = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                       instruction[20], instruction[30:21], 1'b0};
    assign branch_imm = {{19{instruction[31]}}, instruction[31], instruction[7],
                         instruction[30:25], instruction[11:8], 1'b0};
    assign i_imm = {{20{instruction[31]}}, instruction[31:20]};
    assign u_imm = {instruction[31:12], 12'h000};

    assign dec.opcode = opcode;
    assign dec.funct3 = funct3;
    assign dec.rd = instruction[11:7];
    assign dec.rs2_value = rs2_value;
    assign dec.branch_offset = branch_imm;
    assign dec.csr = instruction[31:20];

    // sub only exists in the register form
    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == opc_op && instruction[30]) ? alu_sub : alu_add;
            3'b001: arith_op = alu_sll;
            3'b010: arith_op = alu_slt;
            3'b011: arith_op = alu_sltu;
            3'b100: arith_op = alu_xor;
            3'b101: arith_op = instruction[30] ? alu_sra : alu_srl;
            3'b110: arith_op = alu_or;
            default: arith_op = alu_and;
        endcase
    end

    always_comb begin
        dec.alu_op = alu_add;
        dec.lhs = rs1_value;
        dec.rhs = rs2_value;
        dec.illegal = 1'b0;
        case (opcode)
            opc_lui: begin
                dec.lhs = u_imm;
                dec.rhs = '0;
            end
            opc_auipc: begin
                dec.lhs = u_imm;
                dec.rhs = pc;
            end
            opc_jal: begin
                dec.lhs = jump_imm;
                dec.rhs = pc;
            end
            opc_jalr: dec.rhs = i_imm;
            opc_branch: begin
                case (funct3)
                    3'b000: dec.alu_op = alu_eq;
                    3'b001: dec.alu_op = alu_ne;
                    3'b100: dec.alu_op = alu_slt;
                    3'b101: dec.alu_op = alu_ge;
                    3'b110: dec.alu_op = alu_sltu;
                    3'b111: dec.alu_op = alu_geu;
                    default: dec.illegal = 1'b1;
                endcase
            end
            opc_store: begin
                dec.rhs = store_imm;
                dec.illegal = !(funct3 inside {width_byte, width_half, width_word});
            end
            opc_op_imm: begin
                dec.alu_op = arith_op;
                // shift amount sits in the rs2 field
                dec.rhs = (funct3 == 3'b001 || funct3 == 3'b101) ? {27'b0, rs2} : i_imm;
            end
            opc_op: dec.alu_op = arith_op;
            opc_misc_mem: ;
            opc_system: dec.illegal = funct3 == 3'b100;
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
    import rv_core_pkg::*;
    (
    input wire clk,
    input wire reset_n,
    input reg_idx_t rs1,
    input reg_idx_t rs2,
    output word_t rs1_value,
    output word_t rs2_value,
    input wire wr_en,
    input reg_idx_t wr_idx,
    input word_t wr_data
);

    // x0 has no storage
    word_t regs [1:31];

    assign rs1_value = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_store_align.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_store_align
    import rv_core_pkg::*;
    (
    input wire [2:0] width,
    input wire [1:0] offset,
    input word_t data,
    input wire second_beat,
    output word_t wdata,
    output byte_en_t byte_en,
    output logic split
);

    word_t masked;
    byte_en_t base_en;
    logic [63:0] wide_data;
    logic [7:0] wide_en;

    // zero the lanes the store does not touch
    always_comb begin
        case (width)
            width_byte: begin
                masked = {24'b0, data[7:0]};
                base_en = 4'b0001;
            end
            width_half: begin
                masked = {16'b0, data[15:0]};
                base_en = 4'b0011;
            end
            width_word: begin
                masked = data;
                base_en = 4'b1111;
            end
            default: begin
                masked = '0;
                base_en = 4'b0000;
            end
        endcase
    end

    // upper half of the double word is the spill into the next word
    assign wide_data = {32'b0, masked} << {offset, 3'b000};
    assign wide_en = {4'b0, base_en} << offset;

    assign wdata = second_beat ? wide_data[63:32] : wide_data[31:0];
    assign byte_en = second_beat ? wide_en[7:4] : wide_en[3:0];
    assign split = |wide_en[7:4];

endmodule

`default_nettype wire

// ==== files.f ====
design/rv_core_pkg.sv
design/rv_decode_if.sv
design/rv_alu.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_store_align.sv
design/rv_control.sv
design/rv_core.sv
tb/rv_bus_checker.sv
tb/rv_core_properties.sv
tb/rv_core_tb.sv

// ==== tb/rv_bus_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_bus_checker #(
    parameter logic [31:0] reset_pc = 32'h1000_0000
) (
    input wire clk,
    input wire reset_n,
    input wire ready,
    input wire read_req,
    input wire write_req,
    input wire [31:0] addr,
    input wire [31:0] write_data,
    input wire [3:0] byte_enable,
    output int write_errors,
    output int fetch_errors,
    output int writes_seen,
    output int fetches_seen,
    output logic done
);

    localparam int n_slots = 60;
    localparam int n_writes = 28;
    localparam int n_fetches = 55;

    logic [31:0] exp_waddr [0:n_writes-1];
    logic [31:0] exp_wdata [0:n_writes-1];
    logic [3:0] exp_wbe [0:n_writes-1];
    logic [31:0] exp_fetch [0:n_fetches-1];
    int fill;

    task automatic add_write(input logic [31:0] a, input logic [31:0] d, input logic [3:0] be);
        exp_waddr[fill] = a;
        exp_wdata[fill] = d;
        exp_wbe[fill] = be;
        fill++;
    endtask

    // skipped by the taken branches and jumps
    function automatic logic is_skipped(input int idx);
        return idx == 20 || idx == 24 || idx == 28 || idx == 30 || idx == 34;
    endfunction

    initial begin
        int k;
        fill = 0;
        // arithmetic results
        add_write(32'h2000, 32'h0000006b, 4'hf);
        add_write(32'h2004, 32'hffffff90, 4'hf);
        add_write(32'h2008, 32'hfffffffc, 4'hf);
        add_write(32'h200c, 32'h0000000f, 4'hf);
        add_write(32'h2010, 32'h00000001, 4'hf);
        add_write(32'h2014, 32'h00000000, 4'hf);
        add_write(32'h2018, 32'h0000009b, 4'hf);
        // auipc, jal and jalr link values
        add_write(32'h201c, 32'h10001044, 4'hf);
        add_write(32'h2020, 32'h10000050, 4'hf);
        add_write(32'h2024, 32'h10000060, 4'hf);
        // narrow stores of 0x11223344
        add_write(32'h2040, 32'h00004400, 4'b0010);
        add_write(32'h2040, 32'h44000000, 4'b1000);
        add_write(32'h2050, 32'h33440000, 4'b1100);
        add_write(32'h2060, 32'h00334400, 4'b0110);
        // crossing stores, spill goes to the next word
        add_write(32'h2070, 32'h44000000, 4'b1000);
        add_write(32'h2074, 32'h00000033, 4'b0001);
        add_write(32'h2080, 32'h22334400, 4'b1110);
        add_write(32'h2084, 32'h00000011, 4'b0001);
        add_write(32'h2090, 32'h33440000, 4'b1100);
        add_write(32'h2094, 32'h00001122, 4'b0011);
        add_write(32'h20a0, 32'h44000000, 4'b1000);
        add_write(32'h20a4, 32'h00112233, 4'b0111);
        add_write(32'h20b0, 32'h00000044, 4'b0001);
        add_write(32'h20b4, 32'h00003344, 4'b0011);
        // 42 retired before the instret read
        add_write(32'h20c0, 32'h0000002a, 4'hf);
        add_write(32'h20c4, 32'h00000001, 4'hf);
        add_write(32'h20c8, 32'h00000000, 4'hf);
        // byte in lane two
        add_write(32'h20d0, 32'h00440000, 4'b0100);
        k = 0;
        for (int i = 0; i < n_slots; i++) begin
            if (!is_skipped(i)) begin
                exp_fetch[k] = reset_pc + 4 * i;
                k++;
            end
        end
    end

    assign done = writes_seen == n_writes && fetches_seen == n_fetches;

    always @(posedge clk or negedge reset_n) begin
        int werr;
        int ferr;
        if (!reset_n) begin
            write_errors <= 0;
            fetch_errors <= 0;
            writes_seen <= 0;
            fetches_seen <= 0;
        end else begin
            werr = 0;
            ferr = 0;
            if (done && (read_req || write_req)) begin
                $display("request raised at %0t after the program halted", $time);
                ferr++;
            end
            if (read_req && ready) begin
                if (fetches_seen >= n_fetches) begin
                    $display("fetch at %0t from %h beyond the expected list", $time, addr);
                    ferr++;
                end else begin
                    if (addr !== exp_fetch[fetches_seen]) begin
                        $display("mismatch %0t fetch addr: expected %h got %h", $time,
                                 exp_fetch[fetches_seen], addr);
                        ferr++;
                    end
                    if (byte_enable !== 4'hf) begin
                        $display("mismatch %0t fetch byte_enable: expected f got %h",
                                 $time, byte_enable);
                        ferr++;
                    end
                end
                fetches_seen <= fetches_seen + 1;
            end
            if (write_req && ready) begin
                if (fetches_seen == 0) begin
                    $display("write at %0t came before the first fetch", $time);
                    werr++;
                end
                if (writes_seen >= n_writes) begin
                    $display("extra write at %0t to %h that no instruction should make",
                             $time, addr);
                    werr++;
                end else begin
                    if (addr !== exp_waddr[writes_seen]) begin
                        $display("mismatch %0t addr: expected %h got %h", $time,
                                 exp_waddr[writes_seen], addr);
                        werr++;
                    end
                    if (write_data !== exp_wdata[writes_seen]) begin
                        $display("mismatch %0t write_data: expected %h got %h", $time,
                                 exp_wdata[writes_seen], write_data);
                        werr++;
                    end
                    if (byte_enable !== exp_wbe[writes_seen]) begin
                        $display("mismatch %0t byte_enable: expected %h got %h", $time,
                                 exp_wbe[writes_seen], byte_enable);
                        werr++;
                    end
                end
                writes_seen <= writes_seen + 1;
            end
            write_errors <= write_errors + werr;
            fetch_errors <= fetch_errors + ferr;
        end
    end

endmodule

`default_nettype wire

// ==== tb/rv_core_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_properties
    import rv_core_pkg::*;
    (
    input wire clk,
    input wire reset_n,
    input wire ready,
    input wire read_req,
    input wire write_req,
    input word_t addr,
    input byte_en_t byte_enable,
    input ctrl_state_t state
);

    int failures = 0;

    no_overlap: assert property (@(posedge clk) disable iff (!reset_n)
        !(read_req && write_req))
        else begin
            $error("read and write requests are high together");
            failures++;
        end

    addr_held: assert property (@(posedge clk) disable iff (!reset_n)
        (read_req || write_req) && !ready |=> $stable(addr))
        else begin
            $error("addr changed while a request waited");
            failures++;
        end

    error_sticks: assert property (@(posedge clk) disable iff (!reset_n)
        state == st_error |=> state == st_error)
        else begin
            $error("the error state was left");
            failures++;
        end

    lanes_on_write: assert property (@(posedge clk) disable iff (!reset_n)
        write_req |-> byte_enable != 4'b0000)
        else begin
            $error("write request with no byte enabled");
            failures++;
        end

endmodule

bind rv_control rv_core_properties i_properties (
    .clk(clk), .reset_n(reset_n), .ready(ready), .read_req(read_req),
    .write_req(write_req), .addr(addr), .byte_enable(byte_enable), .state(state)
);

`default_nettype wire

// ==== tb/rv_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb
    import rv_core_pkg::*;
    ();

    localparam logic [31:0] reset_pc = 32'h1000_0000;
    localparam int prog_len = 60;
    localparam int cycle_limit = prog_len * 40;

    logic clk = 1'b0;
    logic reset_n;
    logic ready;
    logic read_data_valid;
    logic [31:0] read_data;
    wire [31:0] addr;
    wire [31:0] write_data;
    wire [3:0] byte_enable;
    wire write_req;
    wire read_req;
    int write_errors, fetch_errors, writes_seen, fetches_seen;
    wire done;
    logic [31:0] prog [0:63];
    logic data_pending;
    int seed;
    int cycles;
    int timeouts;
    int assert_errors;

    always #50 clk = ~clk;

    rv_core #(.reset_pc(reset_pc)) i_dut (
        .reset_n(reset_n), .clk(clk), .ready(ready), .addr(addr),
        .write_data(write_data), .byte_enable(byte_enable), .write_req(write_req),
        .read_req(read_req), .read_data(read_data), .read_data_valid(read_data_valid)
    );

    rv_bus_checker #(.reset_pc(reset_pc)) i_checker (
        .clk(clk), .reset_n(reset_n), .ready(ready), .read_req(read_req),
        .write_req(write_req), .addr(addr), .write_data(write_data),
        .byte_enable(byte_enable), .write_errors(write_errors), .fetch_errors(fetch_errors),
        .writes_seen(writes_seen), .fetches_seen(fetches_seen), .done(done)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, opc_op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [4:0] rd,
                                          input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc_jal};
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] a);
        logic [31:0] idx;
        idx = (a - reset_pc) >> 2;
        return (idx < 64) ? prog[idx] : 32'h0;
    endfunction

    task automatic load_program();
        logic [31:0] skip_marker;
        // a skipped slot that runs writes to 0x2100
        skip_marker = enc_s(width_word, 5'd0, 5'd1, 12'h100);
        for (int i = 0; i < 64; i++) begin
            prog[i] = 32'h0;
        end
        prog[0] = {20'h00002, 5'd1, opc_lui};
        prog[1] = enc_i(opc_op_imm, 2, 3'b000, 0, 12'd100);
        prog[2] = enc_i(opc_op_imm, 3, 3'b000, 0, 12'hff9);
        prog[3] = enc_r(7'h20, 3, 2, 3'b000, 4);
        prog[4] = enc_s(width_word, 4, 1, 12'h000);
        prog[5] = enc_i(opc_op_imm, 5, 3'b001, 3, 12'd4);
        prog[6] = enc_i(opc_op_imm, 6, 3'b101, 3, 12'h401);
        prog[7] = enc_i(opc_op_imm, 7, 3'b101, 3, 12'd28);
        prog[8] = enc_r(7'h00, 2, 3, 3'b010, 8);
        prog[9] = enc_r(7'h00, 2, 3, 3'b011, 9);
        prog[10] = enc_i(opc_op_imm, 10, 3'b100, 2, 12'h0ff);
        for (int r = 5; r <= 10; r++) begin
            prog[r + 6] = enc_s(width_word, 5'(r), 5'd1, 12'(4 * (r - 4)));
        end
        prog[17] = {20'h00001, 5'd11, opc_auipc};
        prog[18] = enc_s(width_word, 11, 1, 12'd28);
        prog[19] = enc_j(12, 21'd8);
        prog[20] = skip_marker;
        prog[21] = enc_s(width_word, 12, 1, 12'd32);
        prog[22] = {20'h00000, 5'd13, opc_auipc};
        prog[23] = enc_i(opc_jalr, 14, 3'b000, 13, 12'd12);
        prog[24] = skip_marker;
        prog[25] = enc_s(width_word, 14, 1, 12'd36);
        prog[26] = enc_b(3'b000, 3, 2, 13'd8);
        prog[27] = enc_b(3'b001, 3, 2, 13'd8);
        prog[28] = skip_marker;
        prog[29] = enc_b(3'b100, 2, 3, 13'd8);
        prog[30] = skip_marker;
        prog[31] = enc_b(3'b101, 2, 3, 13'd8);
        prog[32] = enc_b(3'b110, 2, 3, 13'd8);
        prog[33] = enc_b(3'b111, 2, 3, 13'd8);
        prog[34] = skip_marker;
        prog[35] = {20'h11223, 5'd15, opc_lui};
        prog[36] = enc_i(opc_op_imm, 15, 3'b000, 15, 12'h344);
        prog[37] = enc_s(width_byte, 15, 1, 12'h041);
        prog[38] = enc_s(width_byte, 15, 1, 12'h043);
        prog[39] = enc_s(width_half, 15, 1, 12'h052);
        prog[40] = enc_s(width_half, 15, 1, 12'h061);
        prog[41] = enc_s(width_half, 15, 1, 12'h073);
        prog[42] = enc_s(width_word, 15, 1, 12'h081);
        prog[43] = enc_s(width_word, 15, 1, 12'h092);
        prog[44] = enc_s(width_word, 15, 1, 12'h0a3);
        prog[45] = enc_s(width_byte, 15, 1, 12'h0b0);
        prog[46] = enc_s(width_half, 15, 1, 12'h0b4);
        // csrrs rd, csr, x0
        prog[47] = enc_i(opc_system, 16, 3'b010, 0, csr_instret);
        prog[48] = enc_s(width_word, 16, 1, 12'h0c0);
        prog[49] = enc_i(opc_system, 17, 3'b010, 0, csr_cycle);
        prog[50] = enc_i(opc_system, 18, 3'b010, 0, csr_cycle);
        prog[51] = enc_i(opc_system, 19, 3'b010, 0, csr_cycleh);
        prog[52] = enc_i(opc_system, 20, 3'b010, 0, csr_instreth);
        prog[53] = enc_r(7'h00, 18, 17, 3'b011, 21);
        prog[54] = enc_r(7'h00, 20, 19, 3'b110, 22);
        prog[55] = enc_s(width_word, 21, 1, 12'h0c4);
        prog[56] = enc_s(width_word, 22, 1, 12'h0c8);
        prog[57] = enc_s(width_byte, 15, 1, 12'h0d2);
        prog[58] = enc_i(opc_misc_mem, 0, 3'b000, 0, 12'h000);
        // prog[59] stays zero, an illegal opcode
    endtask

    // memory responder
    always @(posedge clk) begin
        if (!reset_n) begin
            ready <= 1'b0;
            read_data_valid <= 1'b0;
            data_pending <= 1'b0;
        end else begin
            ready <= ($random(seed) & 3) != 0;
            read_data_valid <= 1'b0;
            if (data_pending) begin
                read_data_valid <= 1'b1;
                data_pending <= 1'b0;
            end else if (read_req && ready) begin
                read_data <= fetch_word(addr);
                if ($random(seed) & 1) begin
                    read_data_valid <= 1'b1;
                end else begin
                    data_pending <= 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        seed = 32'h312997bb;
        cycles = 0;
        timeouts = 0;
        assert_errors = 0;
        reset_n = 1'b0;
        ready = 1'b0;
        read_data_valid = 1'b0;
        read_data = 32'h0;
        data_pending = 1'b0;
        load_program();
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        while (!done && cycles < cycle_limit) begin
            @(posedge clk);
        end
        if (!done) begin
            timeouts = 1;
            $display("timeout after %0d cycles with %0d writes and %0d fetches seen",
                     cycles, writes_seen, fetches_seen);
        end else begin
            // the halted core must stay quiet
            repeat (20) @(posedge clk);
        end
        assert_errors = i_dut.i_control.i_properties.failures;
        $display("errors: %0d write, %0d fetch, %0d assertion, %0d timeout", write_errors,
                 fetch_errors, assert_errors, timeouts);
        if (write_errors == 0 && fetch_errors == 0 && assert_errors == 0 && timeouts == 0)
        begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
